/* action_state_top.f */
+incdir+include
design/tetromino_pkg.sv
design/playfield_store.sv
design/piece_shape.sv
design/action_decode.sv
design/drop_finder.sv
design/ghost_render.sv
design/action_state_top.sv
tests/action_state_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module action_state_tb \
    -f action_state_top.f \
    -o action_state_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/action_state_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* include/tb_model.svh */
// reference model of shapes, fit, landing row and candidates
// include inside a testbench module that imports tetromino_pkg
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int MODEL_ROWS = 20;
localparam int MODEL_COLS = 10;

typedef logic [MODEL_ROWS-1:0][MODEL_COLS-1:0] model_board_t;

// dr,dc pairs for tiles 0 to 3 at orientation 0, indexed by type
localparam int MODEL_OFS [8][8] = '{
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{0, -2, 0, -1, 0, 0, 0, 1},
    '{0, -1, 0, 0, -1, -1, -1, 0},
    '{0, -1, 0, 0, 0, 1, -1, 0},
    '{0, -1, 0, 0, 0, 1, -1, -1},
    '{0, -1, 0, 0, 0, 1, -1, 1},
    '{0, -1, 0, 0, -1, 0, -1, 1},
    '{-1, -1, -1, 0, 0, 0, 0, 1}
};

function automatic shape_t model_shape(tile_type_t t, orientation_t o);
    shape_t s;
    int dr;
    int dc;
    int tmp;
    for (int k = 0; k < 4; k++) begin
        dr = MODEL_OFS[t][2*k];
        dc = MODEL_OFS[t][2*k+1];
        // one clockwise quarter turn per step, O stays put
        for (int n = 0; n < int'(o) && t != O; n++) begin
            tmp = dr;
            dr = dc;
            dc = -tmp;
        end
        s[k].dr = dr[2:0];
        s[k].dc = dc[2:0];
    end
    return s;
endfunction

function automatic bit model_fits(model_board_t b, piece_t p, int r);
    shape_t s;
    int tr;
    int tc;
    s = model_shape(p.piece_type, p.orientation);
    for (int k = 0; k < 4; k++) begin
        tr = r + int'(s[k].dr);
        tc = int'(p.col) + int'(s[k].dc);
        if (tc < 0 || tc >= MODEL_COLS || tr >= MODEL_ROWS) return 1'b0;
        if (tr >= 0 && b[tr][tc]) return 1'b0;
    end
    return 1'b1;
endfunction

function automatic int model_landing(model_board_t b, piece_t p);
    int land;
    land = int'(p.row);
    if (model_fits(b, p, land)) begin
        while (land + 1 < MODEL_ROWS && model_fits(b, p, land + 1)) begin
            land++;
        end
    end
    return land;
endfunction

function automatic action_set_t model_actions(piece_t p);
    action_set_t a;
    a.rotate_r  = '{p.row, p.col, orientation_t'((int'(p.orientation) + 1) % 4)};
    a.rotate_l  = '{p.row, p.col, orientation_t'((int'(p.orientation) + 3) % 4)};
    a.move_r    = '{p.row, p.col + 5'd1, p.orientation};
    a.move_l    = '{p.row, p.col - 5'd1, p.orientation};
    a.soft_drop = '{p.row + 5'd1, p.col, p.orientation};
    return a;
endfunction

function automatic ghost_t model_ghost(piece_t p, int land);
    shape_t s;
    ghost_t g;
    int tr;
    int tc;
    s = model_shape(p.piece_type, p.orientation);
    for (int k = 0; k < 4; k++) begin
        tr = land + int'(s[k].dr);
        tc = int'(p.col) + int'(s[k].dc);
        g[k].row = tr[COORD_W-1:0];
        g[k].col = tc[COORD_W-1:0];
    end
    return g;
endfunction

`endif

/* tests/action_state_tb.sv */
// self-checking testbench for the tetromino action and ghost pipeline
// drives board writes and piece requests, compares results with the model
`timescale 1ns/1ps

module action_state_tb
    import tetromino_pkg::*;
();

    localparam int RESULT_TIMEOUT = 10;
    localparam int SETUP_EMPTY    = 0;
    localparam int SETUP_RANDOM   = 1;
    localparam int SETUP_BLOCKED  = 2;
    localparam int BLOCKED_ROW    = 6;
    localparam int TABLE_LEN      = 10;

    logic               clk;
    logic               arst_n;
    logic               req_valid;
    piece_t             req_piece;
    logic               row_wr;
    logic [COORD_W-1:0] row_idx;
    logic [9:0]         row_bits;
    logic               board_clr;
    logic               result_valid;
    action_set_t        actions;
    piece_pos_t         hard_drop;
    ghost_t             ghost;

    `include "tb_model.svh"

    typedef struct {
        piece_t piece;
        int     setup;
    } req_entry_t;

    req_entry_t   req_table [TABLE_LEN];
    model_board_t tb_board;

    action_state_top action_state_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_piece    (req_piece),
        .row_wr       (row_wr),
        .row_idx      (row_idx),
        .row_bits     (row_bits),
        .board_clr    (board_clr),
        .result_valid (result_valid),
        .actions      (actions),
        .hard_drop    (hard_drop),
        .ghost        (ghost)
    );

    always #4 clk = ~clk;

    function automatic piece_t make_piece(tile_type_t t, int row, int col, orientation_t o);
        piece_t p;
        p.piece_type  = t;
        p.row         = row[COORD_W-1:0];
        p.col         = col[COORD_W-1:0];
        p.orientation = o;
        return p;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic write_row(input int idx, input logic [MODEL_COLS-1:0] bits);
        @(negedge clk);
        row_wr   = 1'b1;
        row_idx  = idx[COORD_W-1:0];
        row_bits = bits;
        tb_board[idx] = bits;
        @(negedge clk);
        row_wr = 1'b0;
    endtask

    task automatic clear_board();
        @(negedge clk);
        board_clr = 1'b1;
        tb_board  = '0;
        @(negedge clk);
        board_clr = 1'b0;
    endtask

    // random rows fill the lower part of the board only
    task automatic prepare_board(input int setup);
        clear_board();
        if (setup != SETUP_EMPTY) begin
            for (int r = 12; r < MODEL_ROWS; r++) begin
                write_row(r, MODEL_COLS'($urandom()));
            end
        end
        if (setup == SETUP_BLOCKED) begin
            write_row(BLOCKED_ROW, '1);
        end
    endtask

    task automatic wait_for_result(input int already, output int waited);
        waited = already;
        while (!result_valid) begin
            if (waited >= RESULT_TIMEOUT) begin
                abort_run("result_valid never came after a request");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic check_results(input piece_t p, input model_board_t b);
        int         land;
        piece_pos_t exp_hd;
        land = model_landing(b, p);
        exp_hd.row         = land[COORD_W-1:0];
        exp_hd.col         = p.col;
        exp_hd.orientation = p.orientation;
        check_equal(64'(actions), 64'(model_actions(p)), "actions");
        check_equal(64'(hard_drop), 64'(exp_hd), "hard_drop");
        check_equal(64'(ghost), 64'(model_ghost(p, land)), "ghost");
    endtask

    // on an empty board the lowest ghost tile sits on the bottom row
    task automatic check_resting_low();
        int lowest;
        lowest = 0;
        for (int k = 0; k < 4; k++) begin
            if (int'(ghost[k].row) > lowest) begin
                lowest = int'(ghost[k].row);
            end
        end
        check_equal(64'(lowest), 64'(MODEL_ROWS - 1), "lowest ghost row");
    endtask

    task automatic run_request(input piece_t p, input bit rest_check);
        int waited;
        @(negedge clk);
        req_valid = 1'b1;
        req_piece = p;
        @(negedge clk);
        req_valid = 1'b0;
        wait_for_result(1, waited);
        check_equal(64'(waited), 64'd2, "request to result latency");
        check_results(p, tb_board);
        if (rest_check) begin
            check_resting_low();
        end
        @(negedge clk);
        check_equal(64'(result_valid), 64'd0, "result_valid after its pulse");
    endtask

    task automatic fill_table();
        req_table[0] = '{make_piece(L, 0, 9, ORIENTATION_R), SETUP_EMPTY};
        req_table[1] = '{make_piece(T, 1, 4, ORIENTATION_0), SETUP_RANDOM};
        req_table[2] = '{make_piece(I, 0, 2, ORIENTATION_R), SETUP_RANDOM};
        req_table[3] = '{make_piece(L, 2, 7, ORIENTATION_2), SETUP_RANDOM};
        req_table[4] = '{make_piece(S, 1, 1, ORIENTATION_L), SETUP_RANDOM};
        req_table[5] = '{make_piece(Z, 3, 5, ORIENTATION_0), SETUP_RANDOM};
        req_table[6] = '{make_piece(O, 1, 8, ORIENTATION_0), SETUP_RANDOM};
        // left tile off the board, so no fit at the origin
        req_table[7] = '{make_piece(T, 1, 0, ORIENTATION_0), SETUP_RANDOM};
        req_table[8] = '{make_piece(J, BLOCKED_ROW, 4, ORIENTATION_0), SETUP_BLOCKED};
        req_table[9] = '{make_piece(I, 2, 5, ORIENTATION_0), SETUP_BLOCKED};
    endtask

    initial begin
        int           waited;
        int           current_setup;
        piece_t       first_req;
        piece_t       second_req;
        model_board_t old_board;
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_piece = '0;
        row_wr    = 1'b0;
        row_idx   = '0;
        row_bits  = '0;
        board_clr = 1'b0;
        tb_board  = '0;
        void'($urandom(32'hd85));
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (10) begin
            @(negedge clk);
            check_equal(64'(result_valid), 64'd0, "result_valid while idle");
        end

        // every type and orientation on the empty board
        for (int t = 1; t < 8; t++) begin
            for (int o = 0; o < 4; o++) begin
                run_request(make_piece(tile_type_t'(t), 1, 4, orientation_t'(o)), 1'b1);
            end
        end

        current_setup = -1;
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (req_table[i].setup != current_setup) begin
                prepare_board(req_table[i].setup);
                current_setup = req_table[i].setup;
            end
            run_request(req_table[i].piece, 1'b0);
        end

        clear_board();
        run_request(make_piece(T, 1, 4, ORIENTATION_0), 1'b1);

        // back-to-back requests, bottom row filled under the first one
        first_req  = make_piece(T, 1, 4, ORIENTATION_0);
        second_req = make_piece(J, 1, 3, ORIENTATION_0);
        @(negedge clk);
        req_valid = 1'b1;
        req_piece = first_req;
        row_wr    = 1'b1;
        row_idx   = 5'd19;
        row_bits  = '1;
        old_board = tb_board;
        tb_board[19] = '1;
        @(negedge clk);
        row_wr    = 1'b0;
        req_piece = second_req;
        @(negedge clk);
        req_valid = 1'b0;
        wait_for_result(2, waited);
        check_equal(64'(waited), 64'd2, "first back-to-back latency");
        check_results(first_req, old_board);
        @(negedge clk);
        check_equal(64'(result_valid), 64'd1, "second back-to-back result_valid");
        check_results(second_req, tb_board);
        @(negedge clk);
        check_equal(64'(result_valid), 64'd0, "result_valid after back-to-back pair");

        $display("Testbench passed");
        $finish;
    end

endmodule

/* design/action_state_top.sv */
// action candidates, hard drop and ghost for the falling tetromino
// results appear two cycles after each request strobe
`timescale 1ns/1ps

module action_state_top
    import tetromino_pkg::*;
#(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  piece_t              req_piece,
    input  logic                row_wr,
    input  logic [COORD_W-1:0]  row_idx,
    input  logic [COLS-1:0]     row_bits,
    input  logic                board_clr,
    output logic                result_valid,
    output action_set_t         actions,
    output piece_pos_t          hard_drop,
    output ghost_t              ghost
);

    logic [ROWS-1:0][COLS-1:0] board;
    logic                      s1_valid;
    piece_t                    s1_piece;
    logic [COORD_W-1:0]        s1_landing_row;

    playfield_store #(.ROWS(ROWS), .COLS(COLS)) playfield_store_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .row_wr    (row_wr),
        .board_clr (board_clr),
        .row_idx   (row_idx),
        .row_bits  (row_bits),
        .board     (board)
    );

    action_decode action_decode_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_piece (req_piece),
        .actions   (actions)
    );

    drop_finder #(.ROWS(ROWS), .COLS(COLS)) drop_finder_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_piece      (req_piece),
        .board          (board),
        .s1_valid       (s1_valid),
        .s1_piece       (s1_piece),
        .s1_landing_row (s1_landing_row)
    );

    ghost_render #(.ROWS(ROWS), .COLS(COLS)) ghost_render_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .s1_valid       (s1_valid),
        .s1_piece       (s1_piece),
        .s1_landing_row (s1_landing_row),
        .result_valid   (result_valid),
        .hard_drop      (hard_drop),
        .ghost          (ghost)
    );

endmodule

/* design/ghost_render.sv */
// second pipeline stage, places the shape at the landing row
// registers the ghost tiles, the hard-drop state and the result valid
`timescale 1ns/1ps

module ghost_render
    import tetromino_pkg::*;
#(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               s1_valid,
    input  piece_t             s1_piece,
    input  logic [COORD_W-1:0] s1_landing_row,
    output logic               result_valid,
    output piece_pos_t         hard_drop,
    output ghost_t             ghost
);

    shape_t shape;
    ghost_t tiles;

    piece_shape piece_shape_i (
        .piece_type  (s1_piece.piece_type),
        .orientation (s1_piece.orientation),
        .shape       (shape)
    );

    // offsets sign extended, sums wrap at 32
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            tiles[k].row = s1_landing_row + {{(COORD_W-3){shape[k].dr[2]}}, shape[k].dr};
            tiles[k].col = s1_piece.col + {{(COORD_W-3){shape[k].dc[2]}}, shape[k].dc};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        hard_drop.row         <= s1_landing_row;
        hard_drop.col         <= s1_piece.col;
        hard_drop.orientation <= s1_piece.orientation;
        ghost                 <= tiles;
    end

    // board has to be addressable with the coordinate width
    initial begin
        assert (ROWS <= 2**COORD_W && COLS <= 2**COORD_W)
            else $fatal(1, "board size exceeds the coordinate range");
    end

    back_to_back_results_a: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid && $past(result_valid) |-> $past(s1_valid, 1) && $past(s1_valid, 2));

endmodule

/* design/drop_finder.sv */
// first pipeline stage, finds the hard-drop landing row
// every board row is tested for a fit in parallel, then the run is scanned
`timescale 1ns/1ps

module drop_finder
    import tetromino_pkg::*;
#(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       req_valid,
    input  piece_t                     req_piece,
    input  logic [ROWS-1:0][COLS-1:0]  board,
    output logic                       s1_valid,
    output piece_t                     s1_piece,
    output logic [COORD_W-1:0]         s1_landing_row
);

    shape_t             shape;
    logic [ROWS-1:0]    fit;
    logic [COORD_W-1:0] landing;

    piece_shape piece_shape_i (
        .piece_type  (req_piece.piece_type),
        .orientation (req_piece.orientation),
        .shape       (shape)
    );

    // tiles above the board are free, below or beside it are not
    always_comb begin
        int tile_row;
        int tile_col;
        for (int r = 0; r < ROWS; r++) begin
            fit[r] = 1'b1;
            for (int k = 0; k < 4; k++) begin
                tile_row = r + int'(shape[k].dr);
                tile_col = int'(req_piece.col) + int'(shape[k].dc);
                if (tile_col < 0 || tile_col >= COLS || tile_row >= ROWS) begin
                    fit[r] = 1'b0;
                end else if (tile_row >= 0 && board[tile_row][tile_col]) begin
                    fit[r] = 1'b0;
                end
            end
        end
    end

    // last row of the unbroken run of fits from the origin down
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        landing = req_piece.row;
        for (int r = 0; r < ROWS; r++) begin
            if (r >= req_piece.row) begin
                if (!fit[r]) begin
                    blocked = 1'b1;
                end else if (!blocked) begin
                    landing = r[COORD_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_piece       <= req_piece;
        s1_landing_row <= landing;
    end

    landing_not_above_origin_a: assert property (@(posedge clk) disable iff (!arst_n)
        s1_valid |-> s1_landing_row >= s1_piece.row);

endmodule

/* design/action_decode.sv */
// rotate, move and soft-drop candidates of the falling piece
// delayed two cycles so they line up with the ghost result
`timescale 1ns/1ps

module action_decode
    import tetromino_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  piece_t      req_piece,
    output action_set_t actions
);

    action_set_t cand;
    action_set_t stage1;

    always_comb begin
        cand.rotate_r.row         = req_piece.row;
        cand.rotate_r.col         = req_piece.col;
        cand.rotate_r.orientation = orientation_t'(req_piece.orientation + 2'd1);

        cand.rotate_l.row         = req_piece.row;
        cand.rotate_l.col         = req_piece.col;
        cand.rotate_l.orientation = orientation_t'(req_piece.orientation - 2'd1);

        // columns wrap, validity is judged elsewhere
        cand.move_r.row           = req_piece.row;
        cand.move_r.col           = req_piece.col + 5'd1;
        cand.move_r.orientation   = req_piece.orientation;

        cand.move_l.row           = req_piece.row;
        cand.move_l.col           = req_piece.col - 5'd1;
        cand.move_l.orientation   = req_piece.orientation;

        cand.soft_drop.row         = req_piece.row + 5'd1;
        cand.soft_drop.col         = req_piece.col;
        cand.soft_drop.orientation = req_piece.orientation;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage1  <= '0;
            actions <= '0;
        end else begin
            stage1  <= cand;
            actions <= stage1;
        end
    end

endmodule

/* design/piece_shape.sv */
// tile offsets of a tetromino for its type and orientation
// one table at orientation 0, turned clockwise as often as needed
`timescale 1ns/1ps

module piece_shape
    import tetromino_pkg::*;
(
    input  tile_type_t   piece_type,
    input  orientation_t orientation,
    output shape_t       shape
);

    shape_t base;

    function automatic offset_t ofs(input int dr, input int dc);
        offset_t o;
        o.dr = dr[2:0];
        o.dc = dc[2:0];
        return o;
    endfunction

    // listed tile 3 down to tile 0
    always_comb begin
        case (piece_type)
            T:       base = {ofs(-1, 0), ofs(0, 1), ofs(0, 0), ofs(0, -1)};
            J:       base = {ofs(-1, -1), ofs(0, 1), ofs(0, 0), ofs(0, -1)};
            L:       base = {ofs(-1, 1), ofs(0, 1), ofs(0, 0), ofs(0, -1)};
            S:       base = {ofs(-1, 1), ofs(-1, 0), ofs(0, 0), ofs(0, -1)};
            Z:       base = {ofs(0, 1), ofs(0, 0), ofs(-1, 0), ofs(-1, -1)};
            I:       base = {ofs(0, 1), ofs(0, 0), ofs(0, -1), ofs(0, -2)};
            O:       base = {ofs(-1, 0), ofs(-1, -1), ofs(0, 0), ofs(0, -1)};
            default: base = '0;
        endcase
    end

    // each clockwise step maps (dr,dc) to (dc,-dr)
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (piece_type == O || piece_type == BLANK) begin
                shape[k] = base[k];
            end else begin
                case (orientation)
                    ORIENTATION_R: shape[k] = '{dr: base[k].dc, dc: -base[k].dr};
                    ORIENTATION_2: shape[k] = '{dr: -base[k].dr, dc: -base[k].dc};
                    ORIENTATION_L: shape[k] = '{dr: -base[k].dc, dc: base[k].dr};
                    default:       shape[k] = base[k];
                endcase
            end
        end
    end

endmodule

/* design/playfield_store.sv */
// occupancy of the locked playfield, one bit per cell
// rows are replaced one at a time, the whole board clears at once
`timescale 1ns/1ps

module playfield_store
    import tetromino_pkg::*;
#(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       row_wr,
    input  logic                       board_clr,
    input  logic [COORD_W-1:0]         row_idx,
    input  logic [COLS-1:0]            row_bits,
    output logic [ROWS-1:0][COLS-1:0]  board
);

    // clear wins over a row write in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            board <= '0;
        end else if (board_clr) begin
            board <= '0;
        end else if (row_wr) begin
            board[row_idx] <= row_bits;
        end
    end

    row_idx_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
        row_wr |-> row_idx < ROWS);

endmodule

/* design/tetromino_pkg.sv */
// shared types for the tetromino action and ghost pipeline
// imported by every design module and by the testbench
package tetromino_pkg;

    // row and column coordinates, wrap modulo 32
    localparam int COORD_W = 5;

    typedef enum logic [2:0] {
        BLANK,
        I,
        O,
        T,
        J,
        L,
        S,
        Z
    } tile_type_t;

    // clockwise order, so +1 is a right turn
    typedef enum logic [1:0] {
        ORIENTATION_0,
        ORIENTATION_R,
        ORIENTATION_2,
        ORIENTATION_L
    } orientation_t;

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        orientation_t       orientation;
    } piece_pos_t;

    typedef struct packed {
        tile_type_t         piece_type;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        orientation_t       orientation;
    } piece_t;

    // rows grow downward
    typedef struct packed {
        logic signed [2:0] dr;
        logic signed [2:0] dc;
    } offset_t;

    typedef offset_t [3:0] shape_t;

    typedef struct packed {
        piece_pos_t rotate_r;
        piece_pos_t rotate_l;
        piece_pos_t move_r;
        piece_pos_t move_l;
        piece_pos_t soft_drop;
    } action_set_t;

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } tile_pos_t;

    typedef tile_pos_t [3:0] ghost_t;

endpackage
